//--- Bender.yml
package:
  name: issue_core

sources:
  # Packages first, the record types depend on the opcode enum
  - files:
      - src/aluPkg.sv
      - src/tomasuloPkg.sv
      - src/rsEntry.sv
      - src/rsArray.sv
      - src/aluUnit.sv
      - src/issueCore.sv
  - target: simulation
    files:
      - sim/issueCoreTb.sv

//--- files.f
src/aluPkg.sv
src/tomasuloPkg.sv
src/rsEntry.sv
src/rsArray.sv
src/aluUnit.sv
src/issueCore.sv
sim/issueCoreTb.sv

//--- sim/issueCoreTb.sv
/*
 * Testbench for issueCore, stimulus and expected results from sim/issueTests.txt.
 * Run from the project root so the data file path resolves.
 * Destination tags in the file must all be distinct.
 * Operands naming a finished producer are sent as values, like a rename stage.
 */
`timescale 1ns/1ps
`default_nettype none

module issueCoreTb;

    import tomasuloPkg::*;
    import aluPkg::*;

    localparam int clockPeriod = 8;
    localparam int idleLatency = 3;             // Edges from strobe sampling to CDB launch
    localparam int waitLimit   = 200;           // Cycles allowed per wait loop
    localparam int tagCount    = 1 << tagWidth;

    logic     clock;
    logic     reset;
    logic     dispatchValid;
    dispatchT dispatch;
    logic     rsFull;
    cdbT      cdb;

    dispatchT testList [$];   // Instructions in file order
    int       modeList [$];   // Dispatch timing per instruction

    // Scoreboard indexed by destination tag
    dataT expValue   [tagCount];
    bit   listed     [tagCount];
    bit   expPending [tagCount];   // Dispatched, result not seen yet
    bit   doneTag    [tagCount];
    bit   timedTag   [tagCount];   // Latency checked on arrival
    int   expArrival [tagCount];

    int          cycleCount;
    int          dispatchedCount;
    int          receivedCount;

    issueCore u_dut (
        .clock         (clock),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .rsFull        (rsFull),
        .cdb           (cdb)
    );

    always #(clockPeriod / 2) clock = ~clock;

    always @(posedge clock) cycleCount <= cycleCount + 1;   // Read on falling edges only

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Test aborted");
    endtask

    function automatic int firstPendingTag();
        for (int t = 0; t < tagCount; t++) begin
            if (expPending[t]) return t;
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Test file
    ////////////////////////////////////////////////////////////////////////////

    task automatic decodeOp(input string name, output aluOpT op);
        case (name)
            "add":   op = aluAdd;
            "sub":   op = aluSub;
            "and":   op = aluAnd;
            "or":    op = aluOr;
            "xor":   op = aluXor;
            "sll":   op = aluSll;
            "srl":   op = aluSrl;
            "slt":   op = aluSlt;
            default: reportFailure($sformatf("Unknown opcode %s in test file", name));
        endcase
    endtask

    function automatic operandT makeOperand(input logic ready, input logic [31:0] field);
        operandT result;
        result       = '0;
        result.ready = ready;
        if (ready) result.value = field;   // Value form
        else result.tag = field[tagWidth-1:0];
        return result;
    endfunction

    task automatic loadTests();
        int          fd;
        int          got;
        int          fields;
        int          mode;
        string       line;
        string       opName;
        logic [31:0] dest, rdyA, fieldA, rdyB, fieldB, result;
        dispatchT    instr;
        fd = $fopen("sim/issueTests.txt", "r");
        if (fd == 0) reportFailure("Cannot open sim/issueTests.txt for reading");
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got == 0) break;   // End of file
            fields = $sscanf(line, "%d %s %h %h %h %h %h %h", mode, opName, dest,
                             rdyA, fieldA, rdyB, fieldB, result);
            if (fields == 8) begin   // Comment and blank lines fall through
                decodeOp(opName, instr.op);
                instr.destTag = dest[tagWidth-1:0];
                instr.srcA    = makeOperand(rdyA[0], fieldA);
                instr.srcB    = makeOperand(rdyB[0], fieldB);
                if (listed[instr.destTag]) begin
                    reportFailure($sformatf("Tag %0d listed twice in test file", instr.destTag));
                end
                listed[instr.destTag]   = 1'b1;
                expValue[instr.destTag] = result;
                if (instr.srcA.ready && instr.srcB.ready) begin   // Cross-check the file
                    checkValue("file result", result,
                               aluCompute(instr.op, instr.srcA.value, instr.srcB.value));
                end
                testList.push_back(instr);
                modeList.push_back(mode);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // CDB monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && cdb.valid) begin
            if (!expPending[cdb.tag]) begin
                reportFailure($sformatf("Broadcast of tag %0d at %0t ns not expected or repeated",
                                        cdb.tag, $time));
            end else begin
                checkValue($sformatf("cdb.value (tag %0d)", cdb.tag), cdb.value, expValue[cdb.tag]);
                if (timedTag[cdb.tag]) begin
                    checkValue("cdb arrival cycle", cycleCount, expArrival[cdb.tag]);
                end
                expPending[cdb.tag] = 1'b0;
                doneTag[cdb.tag]    = 1'b1;
                receivedCount++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Dispatcher
    ////////////////////////////////////////////////////////////////////////////

    // Finished producer, hand over its value instead of the tag
    function automatic operandT resolveOperand(input operandT src);
        operandT result;
        result = src;
        if (!src.ready && doneTag[src.tag]) begin
            result.ready = 1'b1;
            result.value = expValue[src.tag];
        end
        return result;
    endfunction

    task automatic waitRoom();
        int waited;
        waited = 0;
        while (rsFull) begin
            @(negedge clock);
            waited++;
            if (waited > waitLimit) begin
                reportFailure($sformatf("Timeout: rsFull stayed high, tag %0d never completed",
                                        firstPendingTag()));
            end
        end
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        while (receivedCount != dispatchedCount) begin
            @(negedge clock);
            waited++;
            if (waited > waitLimit) begin
                reportFailure($sformatf("Timeout: tag %0d never completed on the CDB",
                                        firstPendingTag()));
            end
        end
    endtask

    // Called on a falling edge, one-cycle strobe
    task automatic sendInstr(input dispatchT instr, input bit timed, input bit rename);
        dispatchT sent;
        sent = instr;
        if (rename) begin
            sent.srcA = resolveOperand(instr.srcA);
            sent.srcB = resolveOperand(instr.srcB);
        end
        dispatchValid                = 1'b1;
        dispatch                     = sent;
        expPending[instr.destTag]    = 1'b1;
        timedTag[instr.destTag]      = timed;
        expArrival[instr.destTag]    = cycleCount + idleLatency + 1;   // Seen a falling edge after E3
        dispatchedCount++;
        @(negedge clock);
        dispatchValid = 1'b0;
        dispatch      = '0;
    endtask

    task automatic runOne(input dispatchT instr, input int mode);
        case (mode)
            0: repeat ($urandom_range(2, 0)) @(negedge clock);
            1: waitIdle();
            2: begin
                repeat (idleLatency) @(negedge clock);   // Producer's broadcast cycle
                checkValue("cdb.valid at timed dispatch", cdb.valid, 1);
                checkValue("cdb.tag at timed dispatch", cdb.tag, instr.srcA.tag);
            end
            default: ;
        endcase
        waitRoom();
        sendInstr(instr, mode == 1, mode != 2);   // Timed consumer keeps its tag form
        if (mode == 4) checkValue("rsFull", rsFull, 1);
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        dispatchValid   = 1'b0;
        dispatch        = '0;
        cycleCount      = 0;
        dispatchedCount = 0;
        receivedCount   = 0;
        void'($urandom(36));   // Gap sequence repeatable
        loadTests();
        repeat (3) @(negedge clock);
        reset = 1'b0;
        repeat (4) begin   // Idle core after reset
            @(negedge clock);
            checkValue("rsFull", rsFull, 0);
            checkValue("cdb.valid", cdb.valid, 0);
        end
        foreach (testList[i]) begin
            runOne(testList[i], modeList[i]);
        end
        waitIdle();
        repeat (8) @(negedge clock);   // Room for stray broadcasts
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/issueTests.txt
# mode op dest rdyA valA|tagA rdyB valB|tagB expected   (all but mode and op in hex)
# mode 0 random gap, 1 idle core and fixed latency, 2 on producer broadcast, 3 no gap, 4 no gap then full
1 add 01 1 00000005 1 00000007 0000000c
1 sub 02 1 00000005 1 00000007 fffffffe
0 and 03 1 f0f0ff00 1 0ff0f0f0 00f0f000
0 or  04 1 f0f0ff00 1 0ff0f0f0 fff0fff0
0 xor 05 1 f0f0ff00 1 0ff0f0f0 ff000ff0
0 sll 06 1 00000003 1 00000024 00000030
0 srl 07 1 80000000 1 ffffffe1 40000000
0 slt 08 1 ffffffff 1 00000001 00000001
0 slt 09 1 00000001 1 ffffffff 00000000
0 slt 0a 1 80000000 1 7fffffff 00000001
# Dependent chain
0 add 0b 1 00000010 1 00000020 00000030
0 sub 0c 0 0b 1 00000008 00000028
0 sll 0d 0 0c 1 00000002 000000a0
0 xor 0e 0 0d 0 0c 00000088
# Waiting instruction overtaken by an independent one
0 add 0f 0 0e 1 00000001 00000089
3 or  10 1 00000100 1 00000001 00000101
# Consumer dispatched in the producer's broadcast cycle
1 add 11 1 00001000 1 00000234 00001234
2 sub 12 0 11 1 00000004 00001230
# Four waiters fill the stations
1 add 14 1 00000007 1 00000008 0000000f
3 add 15 0 14 1 00000001 00000010
3 sub 16 0 14 1 0000000f 00000000
3 and 17 0 14 0 14 0000000f
4 sll 18 0 14 1 00000001 0000001e
0 or  19 0 18 1 00000100 0000011e
0 slt 1a 0 16 1 00000001 00000001
# Masked shift amounts and a late chain
0 srl 1b 1 ffffffff 1 0000003f 00000001
0 sll 1c 1 00000001 1 000000ff 80000000
0 sub 1d 1 00000000 1 00000001 ffffffff
0 xor 1e 0 1d 0 1c 7fffffff

//--- src/aluPkg.sv
/*
 * Integer ALU opcodes and the result rule shared by the ALU and checkers.
 * Operands are 32 bit. Shifts use only the low 5 bits of operand B.
 * slt is a signed compare and returns 0 or 1 zero extended.
 */
`default_nettype none

package aluPkg;

    localparam int aluWidth   = 32;   // Operand and result width
    localparam int shamtWidth = 5;    // Shift amount bits taken from operand B

    // Opcode encoding as carried in dispatch and issue records
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSll = 3'd5,
        aluSrl = 3'd6,
        aluSlt = 3'd7
    } aluOpT;

    function automatic logic [aluWidth-1:0] aluCompute(input aluOpT op,
                                                       input logic [aluWidth-1:0] a,
                                                       input logic [aluWidth-1:0] b);
        logic [shamtWidth-1:0] shamt;
        logic [aluWidth-1:0]   result;
        shamt = b[shamtWidth-1:0];                 // Upper bits of B ignored
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;           // Logical, zero fill
            aluSlt:  result = {{(aluWidth-1){1'b0}}, ($signed(a) < $signed(b))};
            default: result = '0;
        endcase
        return result;
    endfunction

endpackage

`default_nettype wire

//--- src/aluUnit.sv
/*
 * Two-stage integer ALU feeding the CDB.
 * Accepts one instruction per cycle, result broadcast two edges later.
 * Sole CDB driver, no arbitration.
 */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic              clock,
    input  logic              reset,
    input  logic              issueValid,
    input  tomasuloPkg::issueT issue,
    output tomasuloPkg::cdbT   cdb
);

    import tomasuloPkg::*;
    import aluPkg::*;

    // Stage 1, computed result
    logic s1Valid;
    tagT  s1Tag;
    dataT s1Result;

    // Stage 2, broadcast register
    logic cdbValid;
    tagT  cdbTag;
    dataT cdbValue;

    ////////////////////////////////////////////////////////////////////////////
    // Valid pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            s1Valid  <= 1'b0;
            cdbValid <= 1'b0;
        end else begin
            s1Valid  <= issueValid;
            cdbValid <= s1Valid;   // One-cycle pulse per result
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (issueValid) begin
            s1Tag    <= issue.destTag;
            s1Result <= aluCompute(issue.op, issue.valueA, issue.valueB);
        end
        if (s1Valid) begin
            cdbTag   <= s1Tag;    // Hold last broadcast otherwise
            cdbValue <= s1Result;
        end
    end

    assign cdb = '{valid: cdbValid, tag: cdbTag, value: cdbValue};

    // Every issued tag is broadcast exactly two edges later
    issueToCdb : assert property (@(posedge clock) disable iff (reset)
        issueValid |=> ##1 (cdb.valid && (cdb.tag == $past(issue.destTag, 2))))
        else $error("aluUnit: issued tag missing from CDB two cycles later");

endmodule

`default_nettype wire

//--- src/issueCore.sv
/*
 * Issue core top, reservation stations plus a single ALU.
 * The ALU's CDB output wakes the entries and is also the result port.
 * Idle-core latency from dispatch strobe to CDB pulse is 3 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module issueCore (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatchValid,
    input  tomasuloPkg::dispatchT dispatch,
    output logic                 rsFull,
    output tomasuloPkg::cdbT      cdb      // Results, also fed back internally
);

    import tomasuloPkg::*;

    logic  issueValid;   // Array to ALU strobe
    issueT issue;

    ////////////////////////////////////////////////////////////////////////////
    // Scheduling
    ////////////////////////////////////////////////////////////////////////////

    rsArray u_rsArray (
        .clock         (clock),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .cdb           (cdb),          // Wakeup path
        .rsFull        (rsFull),
        .issueValid    (issueValid),
        .issue         (issue)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execution
    ////////////////////////////////////////////////////////////////////////////

    aluUnit u_aluUnit (
        .clock      (clock),
        .reset      (reset),
        .issueValid (issueValid),
        .issue      (issue),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

//--- src/rsArray.sv
/*
 * Reservation station array with allocation, selection and issue register.
 * Dispatch goes to the lowest free entry, issue takes the lowest ready one.
 * No back-pressure anywhere. The dispatcher must watch rsFull.
 * Destination tags in flight are assumed distinct.
 */
`timescale 1ns/1ps
`default_nettype none

module rsArray (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatchValid,   // One-cycle strobe
    input  tomasuloPkg::dispatchT dispatch,
    input  tomasuloPkg::cdbT      cdb,
    output logic                 rsFull,          // Combinational from busy bits
    output logic                 issueValid,
    output tomasuloPkg::issueT    issue
);

    import tomasuloPkg::*;

    logic [rsDepth-1:0] busyVec;    // Per-entry occupancy
    logic [rsDepth-1:0] readyVec;   // Per-entry issue request
    logic [rsDepth-1:0] loadVec;    // One-hot allocation
    logic [rsDepth-1:0] freeVec;    // One-hot selection
    issueT              contentsArr [rsDepth];
    issueT              issueNext;

    logic  issueValidReg;
    issueT issueReg;

    // Lowest set bit as a one-hot grant, used for both encoders
    function automatic logic [rsDepth-1:0] lowestSet(input logic [rsDepth-1:0] req);
        logic [rsDepth-1:0] grant;
        logic               found;
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < rsDepth; i++) begin
            if (req[i] && !found) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
        return grant;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Entries
    ////////////////////////////////////////////////////////////////////////////

    for (genvar e = 0; e < rsDepth; e++) begin : gEntry
        rsEntry u_entry (
            .clock    (clock),
            .reset    (reset),
            .load     (loadVec[e]),
            .loadData (dispatch),        // Same record to all, load picks one
            .cdb      (cdb),
            .free     (freeVec[e]),
            .busy     (busyVec[e]),
            .ready    (readyVec[e]),
            .contents (contentsArr[e])
        );
    end

    // Allocation and selection
    assign loadVec = dispatchValid ? lowestSet(~busyVec) : '0;
    assign freeVec = lowestSet(readyVec);   // Oldest index wins, not oldest age
    assign rsFull  = &busyVec;

    // One-hot mux of the selected entry
    always_comb begin
        issueNext = contentsArr[0];
        for (int i = 0; i < rsDepth; i++) begin
            if (freeVec[i]) begin
                issueNext = contentsArr[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            issueValidReg <= 1'b0;
        end else begin
            issueValidReg <= |readyVec;   // Same edge frees the entry
        end
    end

    always_ff @(posedge clock) begin
        if (|readyVec) begin
            issueReg <= issueNext;
        end
    end

    assign issueValid = issueValidReg;
    assign issue      = issueReg;

    // Dispatcher protocol, no strobe while full
    noDispatchWhenFull : assert property (@(posedge clock) disable iff (reset)
        dispatchValid |-> !rsFull)
        else $error("rsArray: dispatch while rsFull is high");

    // At most one entry turns busy per edge
    singleLoad : assert property (@(posedge clock) disable iff (reset)
        $onehot0(busyVec & ~$past(busyVec)))
        else $error("rsArray: more than one entry loaded in a cycle");

endmodule

`default_nettype wire

//--- src/rsEntry.sv
/*
 * Single reservation station entry.
 * load must only hit a free entry, free only a ready one.
 * A load snoops the live CDB so a same-cycle broadcast is not missed.
 * Contents are presented unconditionally, qualify with ready.
 */
`timescale 1ns/1ps
`default_nettype none

module rsEntry (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load,      // Write a new instruction this cycle
    input  tomasuloPkg::dispatchT loadData,
    input  tomasuloPkg::cdbT      cdb,       // Live broadcast for wakeup
    input  logic                 free,      // Selected for issue, release entry
    output logic                 busy,
    output logic                 ready,     // Busy with both operands resolved
    output tomasuloPkg::issueT    contents
);

    import tomasuloPkg::*;

    logic     busyReg;    // Entry holds an instruction
    dispatchT entryReg;   // Opcode, dest tag and both operands

    // Resolve an operand against the CDB, unchanged when no tag match
    function automatic operandT snoop(input operandT src, input cdbT bus);
        operandT result;
        result = src;
        if (!src.ready && bus.valid && (bus.tag == src.tag)) begin
            result.ready = 1'b1;
            result.value = bus.value;
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busyReg <= 1'b0;
        end else if (load) begin
            busyReg <= 1'b1;
        end else if (free) begin
            busyReg <= 1'b0;   // Leaves with the issue register load
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand capture and wakeup
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load) begin
            entryReg.op      <= loadData.op;
            entryReg.destTag <= loadData.destTag;
            entryReg.srcA    <= snoop(loadData.srcA, cdb);   // Catch producer finishing now
            entryReg.srcB    <= snoop(loadData.srcB, cdb);
        end else if (busyReg) begin
            // Waiting operands pick up a matching broadcast
            entryReg.srcA <= snoop(entryReg.srcA, cdb);
            entryReg.srcB <= snoop(entryReg.srcB, cdb);
        end
    end

    assign busy  = busyReg;
    assign ready = busyReg && entryReg.srcA.ready && entryReg.srcB.ready;

    assign contents = '{op:      entryReg.op,
                        destTag: entryReg.destTag,
                        valueA:  entryReg.srcA.value,
                        valueB:  entryReg.srcB.value};

    // Allocation in the array must only pick free entries
    loadOnlyWhenFree : assert property (@(posedge clock) disable iff (reset)
        load |-> !busyReg)
        else $error("rsEntry: load into a busy entry");

    // Selection in the array must only pick ready entries
    freeOnlyWhenReady : assert property (@(posedge clock) disable iff (reset)
        free |-> ready)
        else $error("rsEntry: free of an entry that is not ready");

endmodule

`default_nettype wire

//--- src/tomasuloPkg.sv
/*
 * Sizes and record types of the issue core.
 * Operand value is only meaningful with ready set, tag only with it clear.
 * Depends on aluPkg for the opcode type, compile that first.
 */
`default_nettype none

package tomasuloPkg;

    localparam int tagWidth  = 5;                  // ROB tag width
    localparam int dataWidth = aluPkg::aluWidth;   // Same width as the ALU datapath
    localparam int rsDepth   = 4;                  // Reservation station entries

    typedef logic [tagWidth-1:0]  tagT;
    typedef logic [dataWidth-1:0] dataT;

    // One source operand, either a value or the tag of its producer
    typedef struct packed {
        logic ready;
        tagT  tag;
        dataT value;
    } operandT;

    // Instruction as handed over by the dispatcher
    typedef struct packed {
        aluPkg::aluOpT op;
        tagT           destTag;
        operandT       srcA;
        operandT       srcB;
    } dispatchT;

    // Instruction leaving the array, both operands resolved
    typedef struct packed {
        aluPkg::aluOpT op;
        tagT           destTag;
        dataT          valueA;
        dataT          valueB;
    } issueT;

    // Common data bus broadcast
    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT value;
    } cdbT;

endpackage

`default_nettype wire
